// ==== pixel_out.sv ====
`timescale 1ns/1ps

module pixel_out
(
	input  logic clk,
	input  logic reset,
	vga_sync_if.display sync,
	input  vram_pkg::pixel_t vga_rd_data,
	output logic hsync,
	output logic vsync,
	output logic video_on,
	output vram_pkg::pixel_t rgb
);

	logic hsync_reg;
	logic vsync_reg;
	logic video_on_reg;

	// delay sync by one pixel
	// matches the fetch latency of the refresh byte
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			hsync_reg <= 1'b1;
			vsync_reg <= 1'b1;
			video_on_reg <= 1'b0;
		end
		else if (sync.p_tick)
		begin
			hsync_reg <= sync.hsync;
			vsync_reg <= sync.vsync;
			video_on_reg <= sync.video_on;
		end
	end

	assign hsync = hsync_reg;
	assign vsync = vsync_reg;
	assign video_on = video_on_reg;
	// blank outside the visible area
	assign rgb = video_on_reg ? vga_rd_data : '0;

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build and run the vga frame buffer testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f sources.f \
	--top-module tb_vga_vram -o sim_tb
build_status=$?
if [ $build_status -ne 0 ]; then
	echo "verilator build failed with status $build_status"
	exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
	echo "simulation exited with status $run_status"
	exit 1
fi

if grep -q "^ALL CHECKS PASSED$" sim.log; then
	echo "simulation result: pass"
	exit 0
else
	echo "simulation result: fail"
	exit 1
fi

// ==== sources.f ====
+incdir+.
vram_pkg.sv
vga_sync_if.sv
vga_sync.sv
vram_ctrl.sv
pixel_out.sv
vga_vram_top.sv
sram_model.sv
tb_vga_vram.sv

// ==== sram_model.sv ====
`timescale 1ns/1ps
`include "vram_defs.svh"

module sram_model
(
	input  logic [`SRAM_ADDR_W-1:0] addr,
	input  logic [15:0] wdata,
	output logic [15:0] rdata,
	input  logic ce_n,
	input  logic oe_n,
	input  logic we_n,
	input  logic lb_n,
	input  logic ub_n
);

	// 256K x 16 array
	logic [15:0] mem [0:(1 << `SRAM_ADDR_W) - 1];

	// address hash, odd multiplier folded to 16 bits
	function automatic logic [15:0] pattern_word(logic [`SRAM_ADDR_W-1:0] word_addr);
		logic [31:0] h;
		h = {14'b0, word_addr} * 32'h9e3779b1;
		return h[31:16] ^ h[15:0];
	endfunction

	initial
	begin
		for (int i = 0; i < (1 << `SRAM_ADDR_W); i++)
			mem[i] = pattern_word(i[`SRAM_ADDR_W-1:0]);
	end

	// write taken mid pulse, address and data settled by then
	always @(negedge we_n)
	begin
		#2;
		if (!ce_n && !we_n)
		begin
			if (!lb_n)
				mem[addr][7:0] = wdata[7:0];
			if (!ub_n)
				mem[addr][15:8] = wdata[15:8];
		end
	end

	// async read, bus floats high when outputs off
	assign rdata = (!ce_n && !oe_n) ? mem[addr] : 16'hffff;

endmodule

// ==== tb_vga_vram.sv ====
`timescale 1ns/1ps
`include "vram_defs.svh"

module tb_vga_vram;

	logic clk;
	logic reset;
	logic cpu_mem_wr;
	logic cpu_mem_rd;
	vram_pkg::byte_addr_t cpu_addr;
	vram_pkg::pixel_t cpu_wr_data;
	vram_pkg::pixel_t cpu_rd_data;
	logic [`SRAM_ADDR_W-1:0] sram_addr;
	logic [15:0] sram_dq_out;
	logic sram_dq_oe;
	logic [15:0] sram_dq_in;
	logic [15:0] bus_to_sram;
	logic sram_ce_n;
	logic sram_oe_n;
	logic sram_we_n;
	logic sram_lb_n;
	logic sram_ub_n;
	logic hsync;
	logic vsync;
	logic video_on;
	logic pixel_tick;
	vram_pkg::pixel_t rgb;

	// bytes written by the cpu
	// every other byte keeps the preload
	vram_pkg::pixel_t written [int];
	logic [31:0] rng = 32'h2411da47;
	int cycle = 0;
	int hs_fall = 0;
	int vs_fall = 0;
	int vs_periods = 0;
	logic hs_prev = 1'b1;
	logic vs_prev = 1'b1;
	logic hs_tick_prev = 1'b1;
	logic vs_tick_prev = 1'b1;
	// output scan position
	// known once both syncs have fallen
	int x = 0;
	int y = 0;
	logic x_known = 1'b0;
	logic y_known = 1'b0;

	vga_vram_top u_dut (
		.clk (clk),
		.reset (reset),
		.cpu_mem_wr (cpu_mem_wr),
		.cpu_mem_rd (cpu_mem_rd),
		.cpu_addr (cpu_addr),
		.cpu_wr_data (cpu_wr_data),
		.cpu_rd_data (cpu_rd_data),
		.sram_addr (sram_addr),
		.sram_dq_out (sram_dq_out),
		.sram_dq_oe (sram_dq_oe),
		.sram_dq_in (sram_dq_in),
		.sram_ce_n (sram_ce_n),
		.sram_oe_n (sram_oe_n),
		.sram_we_n (sram_we_n),
		.sram_lb_n (sram_lb_n),
		.sram_ub_n (sram_ub_n),
		.hsync (hsync),
		.vsync (vsync),
		.video_on (video_on),
		.pixel_tick (pixel_tick),
		.rgb (rgb)
	);

	// stands in for the pad buffer
	// undriven bus reads as all ones
	assign bus_to_sram = sram_dq_oe ? sram_dq_out : 16'hffff;

	sram_model u_sram (
		.addr (sram_addr),
		.wdata (bus_to_sram),
		.rdata (sram_dq_in),
		.ce_n (sram_ce_n),
		.oe_n (sram_oe_n),
		.we_n (sram_we_n),
		.lb_n (sram_lb_n),
		.ub_n (sram_ub_n)
	);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// ====================================================================
	// helpers
	// ====================================================================
	function automatic logic [31:0] xorshift(logic [31:0] s);
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	// same hash the memory model preloads with
	function automatic logic [15:0] preload_word(logic [17:0] word_addr);
		logic [31:0] h;
		h = {14'b0, word_addr} * 32'h9e3779b1;
		return h[31:16] ^ h[15:0];
	endfunction

	function automatic vram_pkg::pixel_t expected_byte(int a);
		logic [15:0] w;
		if (written.exists(a))
			return written[a];
		w = preload_word(a[18:1]);
		// odd byte sits in the upper lane
		return a[0] ? w[15:8] : w[7:0];
	endfunction

	task automatic abort_run();
		$display("CHECKS FAILED");
		$fatal(1, "stopped at the first failing check");
	endtask

	task automatic report_mismatch(string name, logic [31:0] got, logic [31:0] want);
		$display("error %s got %h expected %h", name, got, want);
		abort_run();
	endtask

	task automatic report_problem(string msg);
		$display("%s", msg);
		abort_run();
	endtask

	task automatic check_reset_outputs();
		assert (sram_we_n == 1'b1) else report_mismatch("sram_we_n", sram_we_n, 1);
		assert (sram_dq_oe == 1'b0) else report_mismatch("sram_dq_oe", sram_dq_oe, 0);
		assert (rgb == 8'h00) else report_mismatch("rgb", rgb, 0);
		assert (cpu_rd_data == 8'h00) else report_mismatch("cpu_rd_data", cpu_rd_data, 0);
		assert (hsync && vsync) else report_mismatch("hsync,vsync", {hsync, vsync}, 3);
	endtask

	// one-cycle strobe then the address is held until the write is done
	task automatic cpu_write(int a, vram_pkg::pixel_t d);
		cpu_addr = a[18:0];
		cpu_wr_data = d;
		cpu_mem_wr = 1'b1;
		@(negedge clk);
		cpu_mem_wr = 1'b0;
		repeat (3) @(negedge clk);
		written[a] = d;
	endtask

	// read data valid 3 clocks after the strobe
	task automatic cpu_read_check(int a);
		vram_pkg::pixel_t want;
		want = expected_byte(a);
		cpu_addr = a[18:0];
		cpu_mem_rd = 1'b1;
		@(negedge clk);
		cpu_mem_rd = 1'b0;
		repeat (2) @(negedge clk);
		assert (cpu_rd_data == want) else report_mismatch("cpu_rd_data", cpu_rd_data, want);
		@(negedge clk);
	endtask

	task automatic wait_for_row(int row);
		int waited;
		waited = 0;
		while (!(x_known && y_known && y == row))
		begin
			@(negedge clk);
			waited = waited + 1;
			if (waited > 1000000)
				report_problem($sformatf("timeout waiting for scan row %0d", row));
		end
	endtask

	// ====================================================================
	// sync timing and display monitor
	// ====================================================================
	always @(negedge clk)
	begin
		cycle = cycle + 1;
		if (!reset)
		begin
			// hsync and vsync edges in clocks
			if (hs_prev && !hsync)
			begin
				if (hs_fall > 0)
				begin
					assert (cycle - hs_fall == 1600)
					else report_mismatch("hsync period", cycle - hs_fall, 1600);
				end
				hs_fall = cycle;
			end
			if (!hs_prev && hsync && hs_fall > 0)
			begin
				assert (cycle - hs_fall == 192)
				else report_mismatch("hsync low width", cycle - hs_fall, 192);
			end
			if (vs_prev && !vsync)
			begin
				if (vs_fall > 0)
				begin
					assert (cycle - vs_fall == 840000)
					else report_mismatch("vsync period", cycle - vs_fall, 840000);
					vs_periods = vs_periods + 1;
				end
				vs_fall = cycle;
			end
			if (!vs_prev && vsync && vs_fall > 0)
			begin
				assert (cycle - vs_fall == 3200)
				else report_mismatch("vsync low width", cycle - vs_fall, 3200);
			end
			hs_prev = hsync;
			vs_prev = vsync;

			// one output pixel per tick
			// outputs are stable at this edge
			if (pixel_tick)
			begin
				if (hs_tick_prev && !hsync)
				begin
					x = 656;
					x_known = 1'b1;
				end
				else if (x == 799)
				begin
					x = 0;
					y = (y == 524) ? 0 : y + 1;
				end
				else
					x = x + 1;
				if (vs_tick_prev && !vsync)
				begin
					y = 490;
					y_known = 1'b1;
				end
				hs_tick_prev = hsync;
				vs_tick_prev = vsync;

				if (x_known && y_known)
				begin
					assert (video_on == (x < 640 && y < 480))
					else report_mismatch("video_on", video_on, (x < 640 && y < 480));
					if (video_on)
					begin
						assert (rgb == expected_byte(640 * y + x))
						else report_mismatch("rgb", rgb, expected_byte(640 * y + x));
					end
					else
					begin
						assert (rgb == 8'h00) else report_mismatch("rgb", rgb, 0);
					end
				end
			end
		end
	end

	// ====================================================================
	// stimulus
	// ====================================================================
	initial
	begin
		int a;
		reset = 1'b1;
		cpu_mem_wr = 1'b0;
		cpu_mem_rd = 1'b0;
		cpu_addr = '0;
		cpu_wr_data = '0;

		repeat (5)
		begin
			@(negedge clk);
			check_reset_outputs();
		end
		reset = 1'b0;
		// still idle right after release
		repeat (2)
		begin
			@(negedge clk);
			check_reset_outputs();
		end

		// writes above the visible area on both lanes
		// each one followed by a read of its partner byte
		for (int i = 0; i < 24; i++)
		begin
			rng = xorshift(rng);
			a = 307200 + int'(rng % 217088);
			a[0] = i[0];
			rng = xorshift(rng);
			cpu_write(a, rng[7:0]);
			cpu_read_check(a);
			cpu_read_check(a ^ 1);
		end

		// mid frame A rewrite rows that were already scanned
		wait_for_row(0);
		wait_for_row(300);
		for (int i = 0; i < 200; i++)
		begin
			rng = xorshift(rng);
			a = 640 * int'(rng[31:16] % 200) + int'(rng[15:0] % 640);
			rng = xorshift(rng);
			cpu_write(a, rng[7:0]);
		end

		// frame B shows the new bytes
		wait_for_row(0);
		wait_for_row(480);

		assert (vs_periods > 0) else report_problem("vsync period was never measured");
		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

// ==== vga_sync.sv ====
`timescale 1ns/1ps
`include "vram_defs.svh"

module vga_sync
(
	input  logic clk,
	input  logic reset,
	vga_sync_if.source sync
);

	// line and frame lengths
	localparam int H_TOTAL = `H_DISPLAY + `H_FRONT + `H_SYNC + `H_BACK;
	localparam int V_TOTAL = `V_DISPLAY + `V_FRONT + `V_SYNC + `V_BACK;
	// first and last position of each sync pulse
	localparam int H_SYNC_START = `H_DISPLAY + `H_FRONT;
	localparam int H_SYNC_END = H_SYNC_START + `H_SYNC - 1;
	localparam int V_SYNC_START = `V_DISPLAY + `V_FRONT;
	localparam int V_SYNC_END = V_SYNC_START + `V_SYNC - 1;

	logic tick_reg;
	vram_pkg::coord_t h_count;
	vram_pkg::coord_t v_count;
	logic h_end;
	logic v_end;

	// ====================================================================
	// pixel tick and scan counters
	// ====================================================================

	// mod-2 divider, first tick in the second clock after reset
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			tick_reg <= 1'b0;
		else
			tick_reg <= ~tick_reg;
	end

	assign h_end = (h_count == H_TOTAL - 1);
	assign v_end = (v_count == V_TOTAL - 1);

	// counters only move on the tick
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			h_count <= '0;
			v_count <= '0;
		end
		else if (tick_reg)
		begin
			h_count <= h_end ? '0 : h_count + 1'b1;
			// next line at the end of each row
			if (h_end)
				v_count <= v_end ? '0 : v_count + 1'b1;
		end
	end

	// ====================================================================
	// sync decode
	// ====================================================================
	assign sync.p_tick = tick_reg;
	assign sync.pixel_x = h_count;
	assign sync.pixel_y = v_count;
	// hsync low for columns 656..751
	assign sync.hsync = ~((h_count >= H_SYNC_START) && (h_count <= H_SYNC_END));
	// vsync low for rows 490..491
	assign sync.vsync = ~((v_count >= V_SYNC_START) && (v_count <= V_SYNC_END));
	assign sync.video_on = (h_count < `H_DISPLAY) && (v_count < `V_DISPLAY);

	// the divider must never hold the tick for two clocks
	a_tick_alternates: assert property (@(posedge clk) disable iff (reset)
		tick_reg |=> !tick_reg)
		else $error("pixel tick high on consecutive clocks");

endmodule

// ==== vga_sync_if.sv ====
`timescale 1ns/1ps

interface vga_sync_if;

	// current scan position
	vram_pkg::coord_t pixel_x;
	vram_pkg::coord_t pixel_y;

	// pixel clock enable
	// high on every second clock
	logic p_tick;

	// sync levels, active low
	logic hsync;
	logic vsync;
	// inside the 640x480 area
	logic video_on;

	modport source (output pixel_x, pixel_y, p_tick, hsync, vsync, video_on);
	// refresh address generation
	modport vram (input pixel_x, pixel_y, p_tick);
	// output alignment stage
	modport display (input p_tick, hsync, vsync, video_on);

endinterface

// ==== vga_vram_top.sv ====
`timescale 1ns/1ps
`include "vram_defs.svh"

module vga_vram_top
(
	input  logic clk,
	input  logic reset,

	// cpu byte port
	input  logic cpu_mem_wr,
	input  logic cpu_mem_rd,
	input  vram_pkg::byte_addr_t cpu_addr,
	input  vram_pkg::pixel_t cpu_wr_data,
	output vram_pkg::pixel_t cpu_rd_data,

	// external sram
	output logic [`SRAM_ADDR_W-1:0] sram_addr,
	output logic [15:0] sram_dq_out,
	output logic sram_dq_oe,
	input  logic [15:0] sram_dq_in,
	output logic sram_ce_n,
	output logic sram_oe_n,
	output logic sram_we_n,
	output logic sram_lb_n,
	output logic sram_ub_n,

	// video out
	output logic hsync,
	output logic vsync,
	output logic video_on,
	output logic pixel_tick,
	output vram_pkg::pixel_t rgb
);

	vga_sync_if sync_bus ();
	vram_pkg::pixel_t vga_rd_data;

	// ====================================================================
	// timing, memory arbiter and output stage
	// ====================================================================
	vga_sync u_sync (
		.clk (clk),
		.reset (reset),
		.sync (sync_bus.source)
	);

	vram_ctrl u_ctrl (
		.clk (clk),
		.reset (reset),
		.sync (sync_bus.vram),
		.cpu_mem_wr (cpu_mem_wr),
		.cpu_mem_rd (cpu_mem_rd),
		.cpu_addr (cpu_addr),
		.cpu_wr_data (cpu_wr_data),
		.cpu_rd_data (cpu_rd_data),
		.vga_rd_data (vga_rd_data),
		.sram_addr (sram_addr),
		.sram_dq_out (sram_dq_out),
		.sram_dq_oe (sram_dq_oe),
		.sram_dq_in (sram_dq_in),
		.sram_ce_n (sram_ce_n),
		.sram_oe_n (sram_oe_n),
		.sram_we_n (sram_we_n),
		.sram_lb_n (sram_lb_n),
		.sram_ub_n (sram_ub_n)
	);

	pixel_out u_pixel (
		.clk (clk),
		.reset (reset),
		.sync (sync_bus.display),
		.vga_rd_data (vga_rd_data),
		.hsync (hsync),
		.vsync (vsync),
		.video_on (video_on),
		.rgb (rgb)
	);

	// clock enable for an external dac
	assign pixel_tick = sync_bus.p_tick;

endmodule

// ==== vram_ctrl.sv ====
`timescale 1ns/1ps
`include "vram_defs.svh"

module vram_ctrl
(
	input  logic clk,
	input  logic reset,
	vga_sync_if.vram sync,

	// cpu byte port, one-cycle strobes
	input  logic cpu_mem_wr,
	input  logic cpu_mem_rd,
	input  vram_pkg::byte_addr_t cpu_addr,
	input  vram_pkg::pixel_t cpu_wr_data,
	output vram_pkg::pixel_t cpu_rd_data,

	// refresh byte for the display
	output vram_pkg::pixel_t vga_rd_data,

	// sram, data bus split into out, enable and in
	output logic [`SRAM_ADDR_W-1:0] sram_addr,
	output logic [15:0] sram_dq_out,
	output logic sram_dq_oe,
	input  logic [15:0] sram_dq_in,
	output logic sram_ce_n,
	output logic sram_oe_n,
	output logic sram_we_n,
	output logic sram_lb_n,
	output logic sram_ub_n
);

	vram_pkg::vram_state_t state_reg;
	vram_pkg::vram_state_t state_next;
	vram_pkg::byte_addr_t cpu_addr_reg;
	vram_pkg::byte_addr_t y_offset;
	vram_pkg::byte_addr_t vga_addr;
	vram_pkg::byte_addr_t mem_addr;
	vram_pkg::pixel_t wr_data_reg;
	vram_pkg::pixel_t cpu_rd_data_reg;
	vram_pkg::pixel_t cpu_rd_data_next;
	vram_pkg::pixel_t vga_rd_data_reg;
	vram_pkg::pixel_t byte_from_sram;
	logic we_n_reg;
	logic cpu_latch;

	// ====================================================================
	// video refresh read
	// ====================================================================

	// 640*y + x as 512*y + 128*y + x
	assign y_offset = {sync.pixel_y, 9'b0} + {2'b00, sync.pixel_y, 7'b0};
	assign vga_addr = y_offset + {9'b0, sync.pixel_x};

	// byte taken at the end of the tick clock
	always_ff @(posedge clk)
	begin
		if (sync.p_tick)
			vga_rd_data_reg <= byte_from_sram;
	end

	assign vga_rd_data = vga_rd_data_reg;

	// ====================================================================
	// cpu access FSM
	// ====================================================================

	// write request captured on its strobe
	assign cpu_latch = (state_reg == vram_pkg::idle) && cpu_mem_wr;

	always_ff @(posedge clk)
	begin
		if (cpu_latch)
		begin
			cpu_addr_reg <= cpu_addr;
			wr_data_reg <= cpu_wr_data;
		end
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			state_reg <= vram_pkg::idle;
			cpu_rd_data_reg <= '0;
			we_n_reg <= 1'b1;
		end
		else
		begin
			state_reg <= state_next;
			cpu_rd_data_reg <= cpu_rd_data_next;
			// write pulse lasts exactly the wr state
			we_n_reg <= (state_next != vram_pkg::wr);
		end
	end

	always_comb
	begin
		state_next = state_reg;
		cpu_rd_data_next = cpu_rd_data_reg;
		case (state_reg)
			vram_pkg::idle:
				if (cpu_mem_wr)
					// skip the wait when the next clock is free
					state_next = sync.p_tick ? vram_pkg::wr : vram_pkg::waitw;
				else if (cpu_mem_rd)
				begin
					if (sync.p_tick)
						state_next = vram_pkg::rd;
					else
					begin
						// free clock, capture straight away
						cpu_rd_data_next = byte_from_sram;
						state_next = vram_pkg::waitr;
					end
				end
			vram_pkg::rd:
			begin
				cpu_rd_data_next = byte_from_sram;
				state_next = vram_pkg::fetch;
			end
			vram_pkg::waitr:
				state_next = vram_pkg::fetch;
			vram_pkg::fetch:
				state_next = vram_pkg::idle;
			vram_pkg::waitw:
				state_next = vram_pkg::wr;
			vram_pkg::wr:
				state_next = vram_pkg::idle;
			default:
				state_next = vram_pkg::idle;
		endcase
	end

	assign cpu_rd_data = cpu_rd_data_reg;

	// ====================================================================
	// sram pins
	// ====================================================================

	// video first, then latched write address, else live cpu address
	assign mem_addr = sync.p_tick ? vga_addr :
		(!we_n_reg) ? cpu_addr_reg : cpu_addr;

	assign sram_addr = mem_addr[`VRAM_ADDR_W-1:1];
	// bit 0 picks the lane
	assign sram_lb_n = mem_addr[0];
	assign sram_ub_n = ~mem_addr[0];
	assign sram_ce_n = 1'b0;
	// outputs off while writing
	assign sram_oe_n = ~we_n_reg;
	assign sram_we_n = we_n_reg;
	// same byte on both lanes, the lane enable decides
	assign sram_dq_out = {wr_data_reg, wr_data_reg};
	assign sram_dq_oe = ~we_n_reg;
	assign byte_from_sram = mem_addr[0] ? sram_dq_in[15:8] : sram_dq_in[7:0];

	// cpu write must never steal a video fetch
	a_no_write_on_tick: assert property (@(posedge clk) disable iff (reset)
		sync.p_tick |-> sram_we_n)
		else $error("sram write overlaps a video fetch");

	// port contract
	a_single_strobe: assert property (@(posedge clk) disable iff (reset)
		!(cpu_mem_wr && cpu_mem_rd))
		else $error("cpu read and write strobes together");

endmodule

// ==== vram_defs.svh ====
`ifndef VRAM_DEFS_SVH
`define VRAM_DEFS_SVH

// byte address into the 512K x 8 view of the SRAM
`define VRAM_ADDR_W 19
// word address of the 256K x 16 part
`define SRAM_ADDR_W 18
`define COORD_W 10
`define PIXEL_W 8

// horizontal timing in pixels
`define H_DISPLAY 640
`define H_FRONT 16
`define H_SYNC 96
`define H_BACK 48
// vertical timing in lines
`define V_DISPLAY 480
`define V_FRONT 10
`define V_SYNC 2
`define V_BACK 33
`endif

// ==== vram_pkg.sv ====
`include "vram_defs.svh"

package vram_pkg;

	// cpu and video byte address
	typedef logic [`VRAM_ADDR_W-1:0] byte_addr_t;
	// pixel column or row
	typedef logic [`COORD_W-1:0] coord_t;
	// one byte of video memory, shown as 3-3-2 rgb
	typedef logic [`PIXEL_W-1:0] pixel_t;

	// sram arbiter states
	// waitr and rd are the two read paths, waitw and wr the write path
	typedef enum logic [2:0] {idle, waitr, rd, fetch, waitw, wr} vram_state_t;

endpackage
